//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

   // Architectural register file size
   localparam int NUM_ARCH_REGS = 32;

   typedef logic [4:0] reg_addr_t;

   // Carried through the slice without interpretation
   typedef logic [3:0] opcode_t;

   // Decoded micro-op as it leaves decode
   typedef struct packed {
      logic      valid;
      opcode_t   opcode;
      reg_addr_t dst;
      logic      has_dst;
      reg_addr_t src1;
      reg_addr_t src2;
   } uinstr_t;

endpackage

`default_nettype wire

//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;

   // Sized for the largest ROB of 16 entries
   typedef logic [3:0] rob_id_t;

   localparam int NUM_SOURCES = 2;

   // Readiness of one source operand
   typedef struct packed {
      logic    pending;
      rob_id_t robid;
   } src_state_t;

   typedef struct packed {
      src_state_t src1;
      src_state_t src2;
   } rename_t;

   // Packet handed from alloc to the reservation queue
   typedef struct packed {
      isa_pkg::uinstr_t uinstr;
      rob_id_t          robid;
      rename_t          rename;
   } disp_t;

   // Writeback broadcast from the execution side
   typedef struct packed {
      logic    valid;
      rob_id_t robid;
   } wb_t;

endpackage

`default_nettype wire

//--- rtl/rob_tracker.sv
`default_nettype none

module rob_tracker #(
   parameter int ROB_DEPTH = 16
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              alloc_fire,
   input  isa_pkg::uinstr_t  uinstr,
   input  core_pkg::wb_t     wb,
   input  logic              retire,
   output logic              rob_ready,
   output core_pkg::rob_id_t next_robid,
   output core_pkg::rename_t rename
);

   localparam int CNT_W = $clog2(ROB_DEPTH + 1);

   logic [CNT_W-1:0]                  rob_count;
   core_pkg::rob_id_t                 alloc_ptr;
   logic [isa_pkg::NUM_ARCH_REGS-1:0] pending_q;
   core_pkg::rob_id_t                 robid_q [isa_pkg::NUM_ARCH_REGS];
   logic                              dst_write;
   isa_pkg::reg_addr_t                src_addr [core_pkg::NUM_SOURCES];
   core_pkg::src_state_t              src_state [core_pkg::NUM_SOURCES];

   // Allocation pointer and occupancy
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         alloc_ptr <= '0;
         rob_count <= '0;
      end else begin
         if (alloc_fire) begin
            if (alloc_ptr == core_pkg::rob_id_t'(ROB_DEPTH - 1)) begin
               alloc_ptr <= '0;
            end else begin
               alloc_ptr <= alloc_ptr + 1'b1;
            end
         end
         case ({alloc_fire, retire})
            2'b10:   rob_count <= rob_count + CNT_W'(1);
            2'b01:   rob_count <= rob_count - CNT_W'(1);
            default: rob_count <= rob_count;
         endcase
      end
   end

   assign next_robid = alloc_ptr;
   assign rob_ready  = (rob_count != CNT_W'(ROB_DEPTH));

   // Register 0 is hardwired, never marked pending
   assign dst_write = alloc_fire & uinstr.has_dst & (uinstr.dst != '0);

   // Allocation wins over a same-cycle writeback
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending_q <= '0;
      end else begin
         for (int r = 1; r < isa_pkg::NUM_ARCH_REGS; r++) begin
            if (dst_write && uinstr.dst == isa_pkg::reg_addr_t'(r)) begin
               pending_q[r] <= 1'b1;
            end else if (wb.valid && wb.robid == robid_q[r]) begin
               pending_q[r] <= 1'b0;
            end
         end
      end
   end

   // Producer id of the latest writer
   always_ff @(posedge clk) begin
      if (dst_write) begin
         robid_q[uinstr.dst] <= next_robid;
      end
   end

   // Source lookup with writeback bypass
   always_comb begin
      src_addr[0] = uinstr.src1;
      src_addr[1] = uinstr.src2;
      for (int i = 0; i < core_pkg::NUM_SOURCES; i++) begin
         src_state[i].pending = pending_q[src_addr[i]] &
                                ~(wb.valid && wb.robid == robid_q[src_addr[i]]);
         // Id only reported for a source still waiting
         src_state[i].robid   = src_state[i].pending ? robid_q[src_addr[i]] : '0;
      end
   end

   assign rename.src1 = src_state[0];
   assign rename.src2 = src_state[1];

endmodule

`default_nettype wire

//--- rtl/alloc.sv
`default_nettype none

module alloc (
   input  logic              clk,
   input  logic              arst_n,
   input  isa_pkg::uinstr_t  uinstr,
   input  logic              rob_ready,
   input  core_pkg::rob_id_t next_robid,
   input  core_pkg::rename_t rename,
   input  logic              rs_stall,
   output logic              alloc_ready,
   output logic              alloc_fire,
   output logic              disp_valid,
   output core_pkg::disp_t   disp
);

   core_pkg::disp_t disp_new;
   core_pkg::disp_t pkt_q;
   logic            valid_q;
   logic            load;

   assign alloc_ready = rob_ready & ~rs_stall;
   assign alloc_fire  = uinstr.valid & alloc_ready;

   // First stage packet
   always_comb begin
      disp_new        = '0;
      disp_new.uinstr = uinstr;
      disp_new.robid  = next_robid;
      disp_new.rename = rename;
   end

   // Hold a valid packet the queue refuses
   assign load = ~(valid_q & rs_stall);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= alloc_fire;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         pkt_q <= disp_new;
      end
   end

   always_comb begin
      disp              = pkt_q;
      disp.uinstr.valid = valid_q;
   end

   assign disp_valid = valid_q & ~rs_stall;

endmodule

`default_nettype wire

//--- rtl/rs_queue.sv
`default_nettype none

module rs_queue #(
   parameter int RS_DEPTH = 4
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            disp_valid,
   input  core_pkg::disp_t disp,
   input  core_pkg::wb_t   wb,
   input  logic            issue,
   output logic            rs_stall,
   output logic            issue_ready,
   output core_pkg::disp_t issue_pkt
);

   localparam int PTR_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
   localparam int CNT_W = $clog2(RS_DEPTH + 1);

   core_pkg::disp_t  entries [RS_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;
   core_pkg::disp_t  head;

   // Clear each source waiting on the broadcast id
   function automatic core_pkg::disp_t wake(core_pkg::disp_t pkt, core_pkg::wb_t w);
      core_pkg::disp_t res;
      res = pkt;
      if (w.valid && w.robid == pkt.rename.src1.robid) begin
         res.rename.src1.pending = 1'b0;
      end
      if (w.valid && w.robid == pkt.rename.src2.robid) begin
         res.rename.src2.pending = 1'b0;
      end
      return res;
   endfunction

   function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
      return (p == PTR_W'(RS_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign rs_stall = (count == CNT_W'(RS_DEPTH));

   // disp_valid is already qualified by rs_stall
   assign push = disp_valid;
   assign pop  = issue & issue_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase
      end
   end

   // Wakeup also covers the entry being written
   always_ff @(posedge clk) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
         if (push && wr_ptr == PTR_W'(i)) begin
            entries[i] <= wake(disp, wb);
         end else begin
            entries[i] <= wake(entries[i], wb);
         end
      end
   end

   assign head        = entries[rd_ptr];
   assign issue_pkt   = head;
   assign issue_ready = (count != '0) & ~head.rename.src1.pending &
                        ~head.rename.src2.pending;

endmodule

`default_nettype wire

//--- rtl/alloc_top.sv
`default_nettype none

module alloc_top #(
   parameter int ROB_DEPTH = 16,
   parameter int RS_DEPTH  = 4
) (
   input  logic             clk,
   input  logic             arst_n,
   input  isa_pkg::uinstr_t uinstr,
   input  core_pkg::wb_t    wb,
   input  logic             retire,
   input  logic             issue,
   output logic             alloc_ready,
   output logic             issue_ready,
   output core_pkg::disp_t  issue_pkt
);

   logic              rob_ready;
   core_pkg::rob_id_t next_robid;
   core_pkg::rename_t rename;
   logic              alloc_fire;
   logic              disp_valid;
   core_pkg::disp_t   disp;
   logic              rs_stall;

   rob_tracker #(
      .ROB_DEPTH (ROB_DEPTH)
   ) u_rob_tracker (
      .clk        (clk),
      .arst_n     (arst_n),
      .alloc_fire (alloc_fire),
      .uinstr     (uinstr),
      .wb         (wb),
      .retire     (retire),
      .rob_ready  (rob_ready),
      .next_robid (next_robid),
      .rename     (rename)
   );

   alloc u_alloc (
      .clk         (clk),
      .arst_n      (arst_n),
      .uinstr      (uinstr),
      .rob_ready   (rob_ready),
      .next_robid  (next_robid),
      .rename      (rename),
      .rs_stall    (rs_stall),
      .alloc_ready (alloc_ready),
      .alloc_fire  (alloc_fire),
      .disp_valid  (disp_valid),
      .disp        (disp)
   );

   rs_queue #(
      .RS_DEPTH (RS_DEPTH)
   ) u_rs_queue (
      .clk         (clk),
      .arst_n      (arst_n),
      .disp_valid  (disp_valid),
      .disp        (disp),
      .wb          (wb),
      .issue       (issue),
      .rs_stall    (rs_stall),
      .issue_ready (issue_ready),
      .issue_pkt   (issue_pkt)
   );

endmodule

`default_nettype wire

//--- tests/alloc_properties.sv
`default_nettype none

module alloc_properties #(
   parameter int ROB_DEPTH = 16
) (
   input logic             clk,
   input logic             arst_n,
   input isa_pkg::uinstr_t uinstr,
   input logic             retire,
   input logic             issue,
   input logic             alloc_ready,
   input logic             issue_ready,
   input core_pkg::disp_t  issue_pkt
);

   localparam int CNT_W = $clog2(ROB_DEPTH + 1);

   logic [CNT_W-1:0] outstanding;
   logic             fire;

   assign fire = uinstr.valid & alloc_ready;

   // ROB entries allocated and not yet retired
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         outstanding <= '0;
      end else if (fire && !retire) begin
         outstanding <= outstanding + CNT_W'(1);
      end else if (!fire && retire) begin
         outstanding <= outstanding - CNT_W'(1);
      end
   end

   issue_low_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !issue_ready)
      else $error("issue_ready high right after reset");

   head_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (issue_ready && !issue) |=> $stable(issue_pkt))
      else $error("queue head changed without issue");

   rob_full_blocks: assert property (@(posedge clk) disable iff (!arst_n)
      (outstanding == CNT_W'(ROB_DEPTH)) |-> !alloc_ready)
      else $error("alloc_ready high with a full ROB");

endmodule

bind alloc_top alloc_properties #(
   .ROB_DEPTH (ROB_DEPTH)
) u_alloc_properties (
   .clk         (clk),
   .arst_n      (arst_n),
   .uinstr      (uinstr),
   .retire      (retire),
   .issue       (issue),
   .alloc_ready (alloc_ready),
   .issue_ready (issue_ready),
   .issue_pkt   (issue_pkt)
);

`default_nettype wire

//--- tests/alloc_tb.sv
`default_nettype none

module alloc_tb;

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 5;
   // Expected records start at this address of the data file
   localparam int EXP_BASE   = 48;

   logic             clk;
   logic             arst_n;
   isa_pkg::uinstr_t uinstr;
   core_pkg::wb_t    wb;
   logic             retire;
   logic             issue;
   logic             alloc_ready;
   logic             issue_ready;
   core_pkg::disp_t  issue_pkt;

   logic [51:0] mem [128];
   int          stim_count;
   int          exp_count;
   int          row;
   int          exp_idx;
   logic        issue_en;
   logic        running;
   logic        failed;

   alloc_top #(
      .ROB_DEPTH (16),
      .RS_DEPTH  (4)
   ) u_alloc_top (
      .clk         (clk),
      .arst_n      (arst_n),
      .uinstr      (uinstr),
      .wb          (wb),
      .retire      (retire),
      .issue       (issue),
      .alloc_ready (alloc_ready),
      .issue_ready (issue_ready),
      .issue_pkt   (issue_pkt)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Issued packet rebuilt from one expected record
   function automatic core_pkg::disp_t expected_pkt(logic [51:0] w);
      core_pkg::disp_t p;
      p                   = '0;
      p.uinstr.valid      = 1'b1;
      p.uinstr.opcode     = w[43:40];
      p.uinstr.dst        = w[36:32];
      p.uinstr.has_dst    = w[28];
      p.uinstr.src1       = w[24:20];
      p.uinstr.src2       = w[16:12];
      p.robid             = w[11:8];
      p.rename.src1.robid = w[7:4];
      p.rename.src2.robid = w[3:0];
      return p;
   endfunction

   function automatic string diff_field(core_pkg::disp_t got, core_pkg::disp_t want);
      string name;
      if (got.uinstr != want.uinstr) begin
         name = "uinstr";
      end else if (got.robid != want.robid) begin
         name = "robid";
      end else if (got.rename.src1 != want.rename.src1) begin
         name = "rename.src1";
      end else begin
         name = "rename.src2";
      end
      return name;
   endfunction

   task automatic drive_row(logic [51:0] w);
      isa_pkg::uinstr_t u;
      core_pkg::wb_t    b;
      u.valid   = w[48];
      u.opcode  = w[47:44];
      u.dst     = w[40:36];
      u.has_dst = w[32];
      u.src1    = w[28:24];
      u.src2    = w[20:16];
      b.valid   = w[12];
      b.robid   = w[11:8];
      uinstr   <= u;
      wb       <= b;
      retire   <= w[4];
      issue_en  = w[0];
   endtask

   task automatic check_issue();
      core_pkg::disp_t want;
      want = expected_pkt(mem[EXP_BASE + exp_idx]);
      assert (issue_pkt == want) begin
         exp_idx = exp_idx + 1;
      end else begin
         $display("** Error: %0t: issue %0d field %s got %h expected %h", $time, exp_idx,
                  diff_field(issue_pkt, want), issue_pkt, want);
         failed = 1'b1;
      end
   endtask

   always @(posedge clk) begin
      if (running && !failed) begin
         if (issue && issue_ready) begin
            check_issue();
         end
         // Next row once the presented micro-op is taken
         if (!uinstr.valid || alloc_ready) begin
            if (row < stim_count) begin
               drive_row(mem[row + 1]);
               row = row + 1;
            end else begin
               uinstr  <= '0;
               wb      <= '0;
               retire  <= 1'b0;
               issue_en = 1'b1;
            end
         end else begin
            // Held row, its strobes only go out once
            wb     <= '0;
            retire <= 1'b0;
         end
         issue <= issue_en & issue_ready;
      end
   end

   initial begin
      $readmemh("tests/alloc_testdata.txt", mem);
      stim_count = int'(mem[0][15:8]);
      exp_count  = int'(mem[0][7:0]);
      row        = 0;
      exp_idx    = 0;
      issue_en   = 1'b0;
      failed     = 1'b0;
      running    = 1'b0;
      clk        = 1'b0;
      arst_n     = 1'b0;
      uinstr     = '0;
      wb         = '0;
      retire     = 1'b0;
      issue      = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      arst_n  <= 1'b1;
      running <= 1'b1;
      wait (failed || exp_idx == exp_count);
      if (failed) begin
         $display("Errors found");
         $fatal(1, "issued packet mismatch");
      end else begin
         $display("No errors");
         $finish;
      end
   end

   initial begin
      @(posedge arst_n);
      #(CLK_PERIOD * 4 * stim_count);
      $display("Watchdog expired with %0d of %0d packets issued", exp_idx, exp_count);
      $display("Errors found");
      $fatal(1, "simulation did not finish in time");
   end

endmodule

`default_nettype wire

//--- tests/alloc_testdata.txt
// @00 counts: stimulus rows [15:8], expected records [7:0]
// Stimulus: valid opcode dst(2) has_dst src1(2) src2(2) wb_valid wb_robid retire issue_en
// Expected @30: opcode dst(2) has_dst src1(2) src2(2) robid src1_robid src2_robid
@00
1111
@01
1101100000000
1202114000000
1303100000000
1401100000000
1507000000000
1604100000001
1705101001001
1806102031101
1900000001301
1A00001000001
1B00000001201
1C00000000001
1D00000000001
1E00000000001
1F00000000001
1000000000001
1100000000011
@30
10110000000
20211400100
30310000200
40110000300
50700000400
60410000500
70510100630
80610203702
90000000800
A0000100900
B0000000A00
C0000000B00
D0000000C00
E0000000D00
F0000000E00
00000000F00
10000000000

//--- project.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/rob_tracker.sv
rtl/alloc.sv
rtl/rs_queue.sv
rtl/alloc_top.sv
tests/alloc_properties.sv
tests/alloc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module alloc_tb -f project.f -o alloc_sim

out=$(./obj_dir/alloc_sim 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "No errors"
